// ==== logic/IsaPkg.sv ====
package IsaPkg;

  localparam int XLen         = 32;  // data and address width.
  localparam int RegAddrWidth = 5;   // x0 .. x31.

  // major opcodes of the supported subset.
  typedef enum logic [6:0] {
    OpReg    = 7'b0110011,
    OpImm    = 7'b0010011,
    OpLoad   = 7'b0000011,
    OpStore  = 7'b0100011,
    OpBranch = 7'b1100011,
    OpJal    = 7'b1101111,
    OpLui    = 7'b0110111
  } OpCode;

  // funct3 codes, alu group.
  localparam logic [2:0] F3AddSub = 3'b000;
  localparam logic [2:0] F3Sll    = 3'b001;
  localparam logic [2:0] F3Slt    = 3'b010;
  localparam logic [2:0] F3Xor    = 3'b100;
  localparam logic [2:0] F3SrlSra = 3'b101;
  localparam logic [2:0] F3Or     = 3'b110;
  localparam logic [2:0] F3And    = 3'b111;
  // funct3 codes, branch and memory group.
  localparam logic [2:0] F3Beq    = 3'b000;
  localparam logic [2:0] F3Bne    = 3'b001;
  localparam logic [2:0] F3Word   = 3'b010;  // lw / sw only.

  localparam logic [6:0] F7Alt    = 7'b0100000;  // selects sub and sra.

  // ####################################################################
  // instruction formats, all 32 bits, msb first.
  typedef struct packed {
    logic [6:0]              funct7;
    logic [RegAddrWidth-1:0] rs2;
    logic [RegAddrWidth-1:0] rs1;
    logic [2:0]              funct3;
    logic [RegAddrWidth-1:0] rd;
    logic [6:0]              opcode;
  } RFormat;

  typedef struct packed {
    logic [11:0]             imm11to0;
    logic [RegAddrWidth-1:0] rs1;
    logic [2:0]              funct3;
    logic [RegAddrWidth-1:0] rd;
    logic [6:0]              opcode;
  } IFormat;

  typedef struct packed {
    logic [6:0]              imm11to5;
    logic [RegAddrWidth-1:0] rs2;
    logic [RegAddrWidth-1:0] rs1;
    logic [2:0]              funct3;
    logic [4:0]              imm4to0;
    logic [6:0]              opcode;
  } SFormat;

  typedef struct packed {
    logic                    imm12;
    logic [5:0]              imm10to5;
    logic [RegAddrWidth-1:0] rs2;
    logic [RegAddrWidth-1:0] rs1;
    logic [2:0]              funct3;
    logic [3:0]              imm4to1;
    logic                    imm11;
    logic [6:0]              opcode;
  } BFormat;

  typedef struct packed {
    logic                    imm20;
    logic [9:0]              imm10to1;
    logic                    imm11;
    logic [7:0]              imm19to12;
    logic [RegAddrWidth-1:0] rd;
    logic [6:0]              opcode;
  } JFormat;

  typedef struct packed {
    logic [19:0]             imm31to12;
    logic [RegAddrWidth-1:0] rd;
    logic [6:0]              opcode;
  } UFormat;

  // one fetched word, viewed through each format.
  typedef union packed {
    RFormat r;
    IFormat i;
    SFormat s;
    BFormat b;
    JFormat j;
    UFormat u;
  } InstructionWord;

endpackage

// ==== logic/ControlPkg.sv ====
package ControlPkg;

  // instruction class, one per encoding format family.
  typedef enum logic [2:0] {
    RType,
    IType,
    Load,
    Store,
    Branch,
    Jump,
    Upper,
    Illegal  // unknown opcode or unsupported funct3.
  } InstructionTypes;

  // operation within a class.
  typedef enum logic [3:0] {
    Add, Sub, And, Or, Xor,
    Slt, Sll, Srl, Sra,
    Beq, Bne,
    None     // class has no sub-operation.
  } InstructionSubTypes;

  // alu operation select.
  typedef enum logic [3:0] {
    AluAdd, AluSub, AluAnd, AluOr, AluXor,
    AluSlt, AluSll, AluSrl, AluSra
  } AluOps;

  // write-back source.
  typedef enum logic [1:0] {
    FromAlu,
    FromMemory,
    FromPcPlus4,  // jal link value.
    FromImm       // lui.
  } ResultSources;

endpackage

// ==== logic/ControlPath.sv ====
`timescale 1ns/100ps

module ControlPath (
  input  IsaPkg::InstructionWord          instruction,
  input  logic                            zero,
  output ControlPkg::AluOps               aluControl,
  output logic                            aluSrc,
  output logic                            pcSrc,
  output ControlPkg::ResultSources        resultSrc,
  output logic                            memWrite,
  output logic                            regWrite,
  output logic                            illegal,
  output logic [IsaPkg::RegAddrWidth-1:0] rs1,
  output logic [IsaPkg::RegAddrWidth-1:0] rs2,
  output logic [IsaPkg::RegAddrWidth-1:0] rd,
  output ControlPkg::InstructionTypes     instructionType,
  output ControlPkg::InstructionSubTypes  instructionSubType
);
  import IsaPkg::*;
  import ControlPkg::*;

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  InstructionSubTypes aluSub;  // alu group decode, reg and imm forms.

  // field positions are shared by every format.
  assign opcode = instruction.r.opcode;
  assign funct3 = instruction.r.funct3;
  assign funct7 = instruction.r.funct7;
  assign rs1    = instruction.r.rs1;
  assign rs2    = instruction.r.rs2;
  assign rd     = instruction.r.rd;

  // maps funct3/funct7 of the alu group to an operation.
  function automatic InstructionSubTypes aluSubType(
    input logic [2:0] f3,
    input logic [6:0] f7,
    input logic       regForm
  );
    case (f3)
      F3AddSub: aluSubType = (regForm && f7 == F7Alt) ? Sub : Add;  // no subi.
      F3Sll:    aluSubType = Sll;
      F3Slt:    aluSubType = Slt;
      F3Xor:    aluSubType = Xor;
      F3SrlSra: aluSubType = (f7 == F7Alt) ? Sra : Srl;  // srai keeps f7 in imm.
      F3Or:     aluSubType = Or;
      F3And:    aluSubType = And;
      default:  aluSubType = None;  // sltu is not implemented.
    endcase
  endfunction

  // ####################################################################
  // instruction class decode.
  assign aluSub = aluSubType(funct3, funct7, opcode == OpReg);

  always_comb begin
    instructionType    = Illegal;
    instructionSubType = None;
    case (opcode)
      OpReg, OpImm: begin
        instructionSubType = aluSub;
        if (aluSub != None)
          instructionType = (opcode == OpReg) ? RType : IType;
      end
      OpLoad:   if (funct3 == F3Word) instructionType = Load;   // word only.
      OpStore:  if (funct3 == F3Word) instructionType = Store;
      OpBranch: begin
        if (funct3 == F3Beq) begin
          instructionType    = Branch;
          instructionSubType = Beq;
        end else if (funct3 == F3Bne) begin
          instructionType    = Branch;
          instructionSubType = Bne;
        end
      end
      OpJal:    instructionType = Jump;
      OpLui:    instructionType = Upper;
      default:  instructionType = Illegal;
    endcase
  end

  // ####################################################################
  // source select and write strobes.
  always_comb begin
    aluSrc    = 1'b1;     // immediate operand unless told otherwise.
    resultSrc = FromAlu;
    regWrite  = 1'b0;
    memWrite  = 1'b0;
    illegal   = 1'b0;
    case (instructionType)
      RType:  begin aluSrc = 1'b0; regWrite = 1'b1; end
      IType:  regWrite = 1'b1;
      Load:   begin regWrite = 1'b1; resultSrc = FromMemory; end
      Store:  memWrite = 1'b1;  // address = rs1 + imm.
      Branch: aluSrc = 1'b0;    // compare rs1 with rs2.
      Jump:   begin regWrite = 1'b1; resultSrc = FromPcPlus4; end
      Upper:  begin regWrite = 1'b1; resultSrc = FromImm; end
      default: illegal = 1'b1;  // retires as a no-op.
    endcase
  end

  // a store never writes back, an rd write never touches memory.
  always_comb begin
    assert (!(memWrite && regWrite))
      else $error("control: memWrite and regWrite both set");
  end

  // ####################################################################
  // alu operation encode.
  always_comb begin
    case (instructionSubType)
      Add, None: aluControl = AluAdd;  // also load/store address.
      Sub:       aluControl = AluSub;
      Beq, Bne:  aluControl = AluSub;  // zero flag gives equality.
      And:       aluControl = AluAnd;
      Or:        aluControl = AluOr;
      Xor:       aluControl = AluXor;
      Slt:       aluControl = AluSlt;
      Sll:       aluControl = AluSll;
      Srl:       aluControl = AluSrl;
      Sra:       aluControl = AluSra;
      default:   aluControl = AluAdd;
    endcase
  end

  // ####################################################################
  // branch resolution.
  assign pcSrc = (instructionType == Jump)
              || (instructionSubType == Beq &&  zero)
              || (instructionSubType == Bne && !zero);

endmodule

// ==== logic/ImmDecode.sv ====
`timescale 1ns/100ps

module ImmDecode (
  input  IsaPkg::InstructionWord      instruction,
  input  ControlPkg::InstructionTypes instructionType,
  output logic [IsaPkg::XLen-1:0]     immExt
);
  import IsaPkg::*;
  import ControlPkg::*;

  always_comb begin
    case (instructionType)
      // i format, also used for shift amounts.
      IType, Load:
        immExt = {{(XLen-12){instruction.i.imm11to0[11]}}, instruction.i.imm11to0};
      Store:  // split across the rd slot.
        immExt = {{(XLen-12){instruction.s.imm11to5[6]}},
                  instruction.s.imm11to5,
                  instruction.s.imm4to0};
      Branch: // halfword offset, bit 0 implied.
        immExt = {{(XLen-13){instruction.b.imm12}},
                  instruction.b.imm12,
                  instruction.b.imm11,
                  instruction.b.imm10to5,
                  instruction.b.imm4to1,
                  1'b0};
      Jump:   // +/- 1 MiB reach.
        immExt = {{(XLen-21){instruction.j.imm20}},
                  instruction.j.imm20,
                  instruction.j.imm19to12,
                  instruction.j.imm11,
                  instruction.j.imm10to1,
                  1'b0};
      Upper:  // lui value, low bits cleared.
        immExt = {instruction.u.imm31to12, {(XLen-20){1'b0}}};
      default:
        immExt = '0;  // rtype and illegal carry no immediate.
    endcase
  end

endmodule

// ==== logic/RegisterFile.sv ====
`timescale 1ns/100ps

module RegisterFile (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            writeEnable,
  input  logic [IsaPkg::RegAddrWidth-1:0] readAddr1,
  input  logic [IsaPkg::RegAddrWidth-1:0] readAddr2,
  input  logic [IsaPkg::RegAddrWidth-1:0] writeAddr,
  input  logic [IsaPkg::XLen-1:0]         writeData,
  output logic [IsaPkg::XLen-1:0]         readData1,
  output logic [IsaPkg::XLen-1:0]         readData2
);
  import IsaPkg::*;

  localparam int RegCount = 2 ** RegAddrWidth;

  logic [XLen-1:0] regs [RegCount];

  // x0 is cleared at reset and never written, so it reads zero.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int idx = 0; idx < RegCount; idx++)
        regs[idx] <= '0;
    end else if (writeEnable && writeAddr != '0) begin
      regs[writeAddr] <= writeData;  // writes to x0 are dropped.
    end
  end

  // asynchronous reads.
  assign readData1 = regs[readAddr1];
  assign readData2 = regs[readAddr2];

  // x0 stays zero across any write sequence.
  assert property (@(posedge clk) disable iff (!rstN)
    readAddr1 == '0 |-> readData1 == '0)
    else $error("regfile: x0 read back nonzero");

endmodule

// ==== logic/Alu.sv ====
`timescale 1ns/100ps

module Alu (
  input  logic [IsaPkg::XLen-1:0] operandA,
  input  logic [IsaPkg::XLen-1:0] operandB,
  input  ControlPkg::AluOps       aluControl,
  output logic [IsaPkg::XLen-1:0] result,
  output logic                    zero
);
  import IsaPkg::*;
  import ControlPkg::*;

  localparam int ShiftWidth = $clog2(XLen);

  logic [ShiftWidth-1:0] shamt;

  assign shamt = operandB[ShiftWidth-1:0];  // low bits only, upper imm bits ignored.

  always_comb begin
    case (aluControl)
      AluAdd:  result = operandA + operandB;
      AluSub:  result = operandA - operandB;
      AluAnd:  result = operandA & operandB;
      AluOr:   result = operandA | operandB;
      AluXor:  result = operandA ^ operandB;
      AluSlt:  result = {{(XLen-1){1'b0}}, ($signed(operandA) < $signed(operandB))};
      AluSll:  result = operandA << shamt;
      AluSrl:  result = operandA >> shamt;
      AluSra:  result = $unsigned($signed(operandA) >>> shamt);  // sign fill.
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);  // branch equality flag.

endmodule

// ==== logic/DataMemory.sv ====
`timescale 1ns/100ps

module DataMemory #(
  parameter int DataDepth = 256
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    writeEnable,
  input  logic [IsaPkg::XLen-1:0] address,
  input  logic [IsaPkg::XLen-1:0] writeData,
  output logic [IsaPkg::XLen-1:0] readData
);
  import IsaPkg::*;

  localparam int IndexWidth = $clog2(DataDepth);

  logic [XLen-1:0]       mem [DataDepth];
  logic [IndexWidth-1:0] wordIndex;

  // byte address to word index; upper bits dropped, so addresses wrap.
  assign wordIndex = address[IndexWidth+1:2];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int idx = 0; idx < DataDepth; idx++)
        mem[idx] <= '0;  // loads of unwritten words return zero.
    end else if (writeEnable) begin
      mem[wordIndex] <= writeData;
    end
  end

  assign readData = mem[wordIndex];  // combinational read.

  // sw only, so the effective address must be word aligned.
  assert property (@(posedge clk) disable iff (!rstN)
    writeEnable |-> address[1:0] == 2'b00)
    else $error("dmem: misaligned store to %h", address);

endmodule

// ==== logic/ProgramCounter.sv ====
`timescale 1ns/100ps

module ProgramCounter #(
  parameter logic [IsaPkg::XLen-1:0] ResetPc = '0
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    advance,
  input  logic                    pcSrc,
  input  logic [IsaPkg::XLen-1:0] immExt,
  output logic [IsaPkg::XLen-1:0] pc,
  output logic [IsaPkg::XLen-1:0] pcPlus4
);
  import IsaPkg::*;

  logic [XLen-1:0] pcNext;

  assign pcPlus4 = pc + XLen'(4);
  assign pcNext  = pcSrc ? pc + immExt : pcPlus4;  // taken branch or jal.

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      pc <= ResetPc;
    else if (advance)  // one step per strobe.
      pc <= pcNext;
  end

  // branch and jump offsets must keep the pc on a word.
  assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
    else $error("pc: misaligned pc %h", pc);

endmodule

// ==== logic/CoreTop.sv ====
`timescale 1ns/100ps

module CoreTop #(
  parameter int                      DataDepth = 256,
  parameter logic [IsaPkg::XLen-1:0] ResetPc   = '0
) (
  input  logic                            clk,
  input  logic                            rstN,
  input  IsaPkg::InstructionWord          instruction,
  input  logic                            instrValid,
  output logic [IsaPkg::XLen-1:0]         pc,
  output logic                            retireValid,
  output logic [IsaPkg::XLen-1:0]         retirePc,
  output logic [IsaPkg::RegAddrWidth-1:0] retireRd,
  output logic                            retireWrite,
  output logic [IsaPkg::XLen-1:0]         retireData,
  output logic                            retireIllegal
);
  import IsaPkg::*;
  import ControlPkg::*;

  // control.
  AluOps                   aluControl;
  ResultSources            resultSrc;
  InstructionTypes         instructionType;
  logic                    aluSrc, pcSrc, memWrite, regWrite, illegal;
  logic [RegAddrWidth-1:0] rs1, rs2, rd;
  // datapath.
  logic [XLen-1:0]         immExt, readData1, readData2, operandB;
  logic [XLen-1:0]         aluResult, readData, pcPlus4, resultData;
  logic                    zero;

  ControlPath controlPath (
    .instruction(instruction), .zero(zero),
    .aluControl(aluControl), .aluSrc(aluSrc), .pcSrc(pcSrc),
    .resultSrc(resultSrc), .memWrite(memWrite), .regWrite(regWrite),
    .illegal(illegal), .rs1(rs1), .rs2(rs2), .rd(rd),
    .instructionType(instructionType),
    .instructionSubType()  // consumed inside the decoder only.
  );

  ImmDecode immDecode (
    .instruction(instruction), .instructionType(instructionType), .immExt(immExt)
  );

  // state only moves on a strobe.
  RegisterFile registerFile (
    .clk(clk), .rstN(rstN), .writeEnable(regWrite && instrValid),
    .readAddr1(rs1), .readAddr2(rs2), .writeAddr(rd), .writeData(resultData),
    .readData1(readData1), .readData2(readData2)
  );

  assign operandB = aluSrc ? immExt : readData2;

  Alu alu (
    .operandA(readData1), .operandB(operandB), .aluControl(aluControl),
    .result(aluResult), .zero(zero)
  );

  DataMemory #(.DataDepth(DataDepth)) dataMemory (
    .clk(clk), .rstN(rstN), .writeEnable(memWrite && instrValid),
    .address(aluResult), .writeData(readData2), .readData(readData)
  );

  ProgramCounter #(.ResetPc(ResetPc)) programCounter (
    .clk(clk), .rstN(rstN), .advance(instrValid), .pcSrc(pcSrc),
    .immExt(immExt), .pc(pc), .pcPlus4(pcPlus4)
  );

  // ####################################################################
  // write-back select.
  always_comb begin
    case (resultSrc)
      FromAlu:     resultData = aluResult;
      FromMemory:  resultData = readData;
      FromPcPlus4: resultData = pcPlus4;  // jal link.
      FromImm:     resultData = immExt;   // lui.
      default:     resultData = aluResult;
    endcase
  end

  // ####################################################################
  // retire report, one cycle after the strobe.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      retireValid   <= 1'b0;
      retireWrite   <= 1'b0;
      retireIllegal <= 1'b0;
    end else begin
      retireValid   <= instrValid;
      retireWrite   <= instrValid && regWrite;  // includes x0 writes.
      retireIllegal <= instrValid && illegal;
    end
  end

  // payload, only meaningful with retireValid.
  always_ff @(posedge clk) begin
    if (instrValid) begin
      retirePc   <= pc;
      retireRd   <= rd;
      retireData <= resultData;
    end
  end

endmodule

// ==== verification/CoreTopTb.sv ====
`timescale 1ns/100ps

module CoreTopTb;

  localparam int          DataDepth      = 256;
  localparam int          MemIndexWidth  = $clog2(DataDepth);
  localparam logic [31:0] ResetPc        = 32'h0000_0100;
  localparam int          ImemIndexWidth = 9;  // 512 instruction words.
  localparam int          MaxCycles      = 2000;  // all tests retire about 60 instructions.

  // rv32i major opcodes.
  localparam logic [6:0] OpcReg    = 7'b0110011;
  localparam logic [6:0] OpcImm    = 7'b0010011;
  localparam logic [6:0] OpcLoad   = 7'b0000011;
  localparam logic [6:0] OpcStore  = 7'b0100011;
  localparam logic [6:0] OpcBranch = 7'b1100011;
  localparam logic [6:0] OpcJal    = 7'b1101111;
  localparam logic [6:0] OpcLui    = 7'b0110111;

  logic        clk;
  logic        rstN;
  logic [31:0] instruction;
  logic        instrValid;
  logic [31:0] pc;
  logic        retireValid;
  logic [31:0] retirePc;
  logic [4:0]  retireRd;
  logic        retireWrite;
  logic [31:0] retireData;
  logic        retireIllegal;

  logic [31:0] imem [2 ** ImemIndexWidth];  // instruction memory model.
  logic [31:0] programWords [$];            // program being assembled.
  logic [31:0] modelRegs [32];
  logic [31:0] modelMem [DataDepth];
  logic [31:0] modelPc;
  int          cycleCount = 0;
  integer      seed;

  CoreTop #(.DataDepth(DataDepth), .ResetPc(ResetPc)) dut_i (
    .clk(clk), .rstN(rstN), .instruction(instruction), .instrValid(instrValid),
    .pc(pc), .retireValid(retireValid), .retirePc(retirePc), .retireRd(retireRd),
    .retireWrite(retireWrite), .retireData(retireData), .retireIllegal(retireIllegal)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period.
  end

  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= MaxCycles)
      stopWithFailure("timeout: the tests did not finish within the cycle limit");
  end

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
      else stopWithFailure($sformatf("error at %0d ns: %s expected %h, got %h",
                                     $time, what, expected, actual));
  endtask

  // ####################################################################
  // instruction encoders.
  function automatic logic [31:0] regOp(input logic [2:0] f3, input logic alt,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    regOp = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, OpcReg};
  endfunction

  function automatic logic [31:0] immOp(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    immOp = {imm, rs1, f3, rd, opc};  // also lw.
  endfunction

  function automatic logic [31:0] storeOp(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    storeOp = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpcStore};
  endfunction

  function automatic logic [31:0] branchOp(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
    branchOp = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OpcBranch};
  endfunction

  function automatic logic [31:0] jalOp(input logic [4:0] rd, input logic [20:0] off);
    jalOp = {off[20], off[10:1], off[11], off[19:12], rd, OpcJal};
  endfunction

  function automatic logic [31:0] luiOp(input logic [4:0] rd, input logic [19:0] imm);
    luiOp = {imm, rd, OpcLui};
  endfunction

  // lui plus addi; the +0x800 cancels the sign of the low part.
  task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    programWords.push_back(luiOp(rd, upper[31:12]));
    programWords.push_back(immOp(OpcImm, 3'b000, rd, rd, value[11:0]));
  endtask

  // ####################################################################
  // reference model built from the architectural rules.
  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  aluRef = alt ? a - b : a + b;
      3'b001:  aluRef = a << b[4:0];
      3'b010:  aluRef = {31'b0, $signed(a) < $signed(b)};
      3'b100:  aluRef = a ^ b;
      3'b110:  aluRef = a | b;
      3'b111:  aluRef = a & b;
      default: begin
        if (alt)
          aluRef = $unsigned($signed(a) >>> b[4:0]);  // sra.
        else
          aluRef = a >> b[4:0];
      end
    endcase
  endfunction

  task automatic modelExecute(input logic [31:0] w, output logic wr,
                              output logic [31:0] data, output logic bad);
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] a, b, addr, nextPc;
    f3     = w[14:12];
    alt    = (w[31:25] == 7'b0100000);
    a      = modelRegs[w[19:15]];
    b      = modelRegs[w[24:20]];
    wr     = 1'b0;
    bad    = 1'b0;
    data   = '0;
    nextPc = modelPc + 32'd4;
    case (w[6:0])
      OpcReg, OpcImm: begin
        bad = (f3 == 3'b011);  // sltu and sltiu are not part of the core.
        wr  = !bad;
        if (w[6:0] == OpcReg)
          data = aluRef(f3, alt, a, b);
        else
          data = aluRef(f3, alt && f3 == 3'b101, a, {{20{w[31]}}, w[31:20]});
      end
      OpcLoad: begin
        addr = a + {{20{w[31]}}, w[31:20]};
        bad  = (f3 != 3'b010);
        wr   = !bad;
        data = modelMem[addr[MemIndexWidth+1:2]];  // index wraps.
      end
      OpcStore: begin
        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        bad  = (f3 != 3'b010);
        if (!bad)
          modelMem[addr[MemIndexWidth+1:2]] = b;
      end
      OpcBranch: begin
        bad = (f3 != 3'b000 && f3 != 3'b001);
        if (!bad && ((a == b) == (f3 == 3'b000)))
          nextPc = modelPc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      OpcJal: begin
        wr     = 1'b1;
        data   = modelPc + 32'd4;  // link value.
        nextPc = modelPc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      OpcLui: begin
        wr   = 1'b1;
        data = {w[31:12], 12'b0};
      end
      default: bad = 1'b1;
    endcase
    if (wr && w[11:7] != 5'd0)
      modelRegs[w[11:7]] = data;
    modelPc = nextPc;
  endtask

  // ####################################################################
  // one fetch, strobe and retire check.
  task automatic stepCore();
    logic [31:0] word, strobePc, expData;
    logic        expWrite, expIllegal;
    int          waited;
    checkValue("pc", modelPc, pc);
    strobePc    = modelPc;
    word        = imem[pc[ImemIndexWidth+1:2]];
    instruction = word;
    instrValid  = 1'b1;
    @(posedge clk);
    #1;
    instrValid = 1'b0;
    modelExecute(word, expWrite, expData, expIllegal);
    waited = 1;
    while (!retireValid && waited < 8) begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (retireValid)
      else stopWithFailure("retireValid never rose after an instruction strobe");
    checkValue("retire latency", 32'd1, 32'(waited));
    checkValue("retirePc", strobePc, retirePc);
    checkValue("retireWrite", 32'(expWrite), 32'(retireWrite));
    checkValue("retireIllegal", 32'(expIllegal), 32'(retireIllegal));
    if (expWrite) begin
      checkValue("retireRd", 32'(word[11:7]), 32'(retireRd));
      checkValue("retireData", expData, retireData);
    end
  endtask

  // places the assembled words at the model pc and runs until pc leaves them.
  task automatic runProgram();
    logic [31:0] startPc;
    logic [31:0] endPc;
    startPc = modelPc;
    endPc   = modelPc + 32'(4 * programWords.size());
    foreach (programWords[i])
      imem[startPc[ImemIndexWidth+1:2] + ImemIndexWidth'(i)] = programWords[i];
    programWords.delete();
    while (modelPc >= startPc && modelPc < endPc)
      stepCore();
    // an idle cycle retires nothing and leaves the pc alone.
    @(posedge clk);
    #1;
    checkValue("retireValid after idle cycle", 32'd0, 32'(retireValid));
    checkValue("retireWrite after idle cycle", 32'd0, 32'(retireWrite));
    checkValue("pc after idle cycle", modelPc, pc);
  endtask

  // ####################################################################
  // directed tests.
  task automatic checkResetState();
    checkValue("pc after reset", ResetPc, pc);
    checkValue("retireValid after reset", 32'd0, 32'(retireValid));
    checkValue("retireWrite after reset", 32'd0, 32'(retireWrite));
  endtask

  task automatic exerciseAlu();
    logic [31:0] value;
    logic [11:0] imm;
    for (int r = 1; r <= 4; r++) begin
      value = $random(seed);
      loadConst(5'(r), value);  // random operands in x1..x4.
    end
    for (int k = 0; k < 8; k++) begin
      if (k != 3) begin
        value = $random(seed);
        imm   = (k == 1 || k == 5) ? {7'b0, value[4:0]} : value[11:0];  // shamt.
        programWords.push_back(regOp(3'(k), 1'b0, 5'(10 + k), 5'(1 + k % 4), 5'(2 + k % 3)));
        programWords.push_back(immOp(OpcImm, 3'(k), 5'(18 + k), 5'(1 + k % 4), imm));
      end
    end
    programWords.push_back(regOp(3'b000, 1'b1, 5'd28, 5'd1, 5'd2));  // sub.
    programWords.push_back(regOp(3'b101, 1'b1, 5'd29, 5'd3, 5'd4));  // sra.
    programWords.push_back(immOp(OpcImm, 3'b101, 5'd26, 5'd2, 12'h40B));  // srai 11.
    programWords.push_back(regOp(3'b000, 1'b0, 5'd30, 5'd10, 5'd18));  // reads back results.
    runProgram();
  endtask

  task automatic zeroRegisterWrites();
    programWords.push_back(immOp(OpcImm, 3'b000, 5'd0, 5'd1, 12'h123));
    programWords.push_back(regOp(3'b000, 1'b0, 5'd0, 5'd2, 5'd3));
    programWords.push_back(luiOp(5'd0, 20'hABCDE));
    programWords.push_back(regOp(3'b110, 1'b0, 5'd6, 5'd0, 5'd0));  // x0 | x0.
    programWords.push_back(regOp(3'b000, 1'b0, 5'd7, 5'd0, 5'd1));
    runProgram();
  endtask

  task automatic loadStoreWords();
    programWords.push_back(immOp(OpcImm, 3'b000, 5'd20, 5'd0, 12'h040));  // base 0x40.
    programWords.push_back(immOp(OpcImm, 3'b000, 5'd21, 5'd0, 12'h440));  // aliases 0x40.
    programWords.push_back(storeOp(5'd1, 5'd20, 12'h000));
    programWords.push_back(storeOp(5'd2, 5'd20, 12'h008));
    programWords.push_back(storeOp(5'd4, 5'd20, 12'hFFC));  // negative offset.
    programWords.push_back(immOp(OpcLoad, 3'b010, 5'd11, 5'd20, 12'h000));
    programWords.push_back(immOp(OpcLoad, 3'b010, 5'd12, 5'd20, 12'h008));
    programWords.push_back(immOp(OpcLoad, 3'b010, 5'd13, 5'd20, 12'h004));  // never written.
    programWords.push_back(immOp(OpcLoad, 3'b010, 5'd14, 5'd20, 12'hFFC));
    programWords.push_back(storeOp(5'd3, 5'd20, 12'h000));  // overwrite.
    programWords.push_back(immOp(OpcLoad, 3'b010, 5'd15, 5'd20, 12'h000));
    programWords.push_back(immOp(OpcLoad, 3'b010, 5'd16, 5'd21, 12'h000));
    runProgram();
  endtask

  task automatic branchesAndJumps();
    programWords.push_back(immOp(OpcImm, 3'b000, 5'd22, 5'd0, 12'd7));
    programWords.push_back(immOp(OpcImm, 3'b000, 5'd23, 5'd0, 12'd7));
    programWords.push_back(immOp(OpcImm, 3'b000, 5'd24, 5'd0, 12'd9));
    programWords.push_back(branchOp(3'b000, 5'd22, 5'd23, 13'd8));  // beq taken.
    programWords.push_back(32'h0000_0000);                          // skipped.
    programWords.push_back(branchOp(3'b000, 5'd22, 5'd24, 13'd8));  // beq not taken.
    programWords.push_back(branchOp(3'b001, 5'd22, 5'd24, 13'd8));  // bne taken.
    programWords.push_back(32'h0000_0000);
    programWords.push_back(branchOp(3'b001, 5'd22, 5'd23, 13'd8));  // bne not taken.
    programWords.push_back(jalOp(5'd25, 21'd12));
    programWords.push_back(immOp(OpcImm, 3'b000, 5'd26, 5'd0, 12'd1));  // via backward jal.
    programWords.push_back(jalOp(5'd0, 21'd12));                         // leaves the program.
    programWords.push_back(jalOp(5'd27, 21'h1F_FFF8));                   // back by 8.
    programWords.push_back(32'h0000_0000);
    runProgram();
  endtask

  task automatic illegalOpcode();
    programWords.push_back(immOp(OpcImm, 3'b000, 5'd31, 5'd0, 12'h5A5));
    programWords.push_back(32'hFFFF_FFFF);                                // rd field is x31.
    programWords.push_back(32'h0000_0000);
    programWords.push_back(immOp(OpcLoad, 3'b000, 5'd31, 5'd0, 12'h000));  // lb.
    programWords.push_back(branchOp(3'b010, 5'd0, 5'd0, 13'd8));           // bad funct3.
    programWords.push_back(regOp(3'b000, 1'b0, 5'd9, 5'd31, 5'd0));        // x31 intact.
    runProgram();
  endtask

  initial begin
    seed        = 50754;
    rstN        = 1'b0;
    instrValid  = 1'b0;
    instruction = '0;
    modelPc     = ResetPc;
    for (int r = 0; r < 32; r++)
      modelRegs[r] = '0;
    for (int m = 0; m < DataDepth; m++)
      modelMem[m] = '0;
    repeat (3) @(posedge clk);
    #1;
    rstN = 1'b1;
    checkResetState();
    exerciseAlu();
    zeroRegisterWrites();
    loadStoreWords();
    branchesAndJumps();
    illegalOpcode();
    checkValue("final pc", modelPc, pc);
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== files.f ====
logic/IsaPkg.sv
logic/ControlPkg.sv
logic/ControlPath.sv
logic/ImmDecode.sv
logic/RegisterFile.sv
logic/Alu.sv
logic/DataMemory.sv
logic/ProgramCounter.sv
logic/CoreTop.sv
verification/CoreTopTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= CoreTopTb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := $(shell grep '\.sv$$' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
